// ==== src/tile_pkg.sv ====
package tile_pkg;

    // bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int BE_W   = 4;

    // interrupt lines
    localparam int IRQ_NUM_POW    = 4;
    localparam int IRQ_NUM        = 2 ** IRQ_NUM_POW;
    localparam int TIMER_IRQ_LINE = 1;

    // address map
    localparam int XIF_BITSEL = 31;
    localparam int SFR_BITSEL = 20;
    localparam int RAM_WORDS  = 1024;
    localparam int RAM_AW     = $clog2(RAM_WORDS);

    // outstanding read tracking in the decoder
    localparam int RD_CNT_W = 3;
    localparam int RD_MAX   = 2 ** RD_CNT_W - 1;

    // sfr byte offsets, word select is bits 4:2
    localparam int SFR_OFS_W = 5;
    localparam logic [SFR_OFS_W-1:0] SFR_ID           = 5'd0;
    localparam logic [SFR_OFS_W-1:0] SFR_SW_RESET     = 5'd4;
    localparam logic [SFR_OFS_W-1:0] SFR_IRQ_EN       = 5'd8;
    localparam logic [SFR_OFS_W-1:0] SFR_TIMER_PERIOD = 5'd12;
    localparam logic [SFR_OFS_W-1:0] SFR_TIMER_VALUE  = 5'd16;
    localparam logic [SFR_OFS_W-1:0] SFR_SGI          = 5'd20;

    localparam logic SW_RESET_DEFAULT = 1'b0;

    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_SFR,
        TGT_XIF
    } target_e;

endpackage

// ==== src/tile_addr_decoder.sv ====
module tile_addr_decoder
    import tile_pkg::*;
(
    input  logic              clk_i
    , input  logic              rst_i

    , input  logic              host_req_valid_i
    , output logic              host_req_ready_o
    , input  logic              host_we_i
    , input  logic [ADDR_W-1:0] host_addr_i
    , input  logic [BE_W-1:0]   host_be_i
    , input  logic [DATA_W-1:0] host_wdata_i
    , output logic              host_resp_valid_o
    , output logic [DATA_W-1:0] host_rdata_o

    , output logic              ram_req_valid_o
    , input  logic              ram_req_ready_i
    , output logic              ram_we_o
    , output logic [ADDR_W-1:0] ram_addr_o
    , output logic [BE_W-1:0]   ram_be_o
    , output logic [DATA_W-1:0] ram_wdata_o
    , input  logic              ram_resp_valid_i
    , input  logic [DATA_W-1:0] ram_rdata_i

    , output logic              sfr_req_valid_o
    , input  logic              sfr_req_ready_i
    , output logic              sfr_we_o
    , output logic [ADDR_W-1:0] sfr_addr_o
    , output logic [BE_W-1:0]   sfr_be_o
    , output logic [DATA_W-1:0] sfr_wdata_o
    , input  logic              sfr_resp_valid_i
    , input  logic [DATA_W-1:0] sfr_rdata_i

    , output logic              xif_req_valid_o
    , input  logic              xif_req_ready_i
    , output logic              xif_we_o
    , output logic [ADDR_W-1:0] xif_addr_o
    , output logic [BE_W-1:0]   xif_be_o
    , output logic [DATA_W-1:0] xif_wdata_o
    , input  logic              xif_resp_valid_i
    , input  logic [DATA_W-1:0] xif_rdata_i
);

    target_e               req_tgt;
    target_e               rd_tgt;
    logic [RD_CNT_W-1:0]   rd_cnt;
    logic                  stall;
    logic                  fwd_valid;
    logic                  tgt_ready;
    logic                  rd_accept;

    always_comb
    begin
        if (host_addr_i[XIF_BITSEL])
            req_tgt = TGT_XIF;
        else if (host_addr_i[SFR_BITSEL])
            req_tgt = TGT_SFR;
        else
            req_tgt = TGT_RAM;
    end

    // keep read responses in order: only same-target reads may overlap
    assign stall = (rd_cnt != '0)
                   && (host_we_i || (req_tgt != rd_tgt) || (rd_cnt == RD_CNT_W'(RD_MAX)));
    assign fwd_valid = host_req_valid_i && !stall;

    assign ram_req_valid_o = fwd_valid && (req_tgt == TGT_RAM);
    assign sfr_req_valid_o = fwd_valid && (req_tgt == TGT_SFR);
    assign xif_req_valid_o = fwd_valid && (req_tgt == TGT_XIF);

    assign ram_we_o    = host_we_i;
    assign ram_addr_o  = host_addr_i;
    assign ram_be_o    = host_be_i;
    assign ram_wdata_o = host_wdata_i;
    assign sfr_we_o    = host_we_i;
    assign sfr_addr_o  = host_addr_i;
    assign sfr_be_o    = host_be_i;
    assign sfr_wdata_o = host_wdata_i;
    assign xif_we_o    = host_we_i;
    assign xif_addr_o  = host_addr_i;
    assign xif_be_o    = host_be_i;
    assign xif_wdata_o = host_wdata_i;

    always_comb
    begin
        case (req_tgt)
            TGT_SFR: tgt_ready = sfr_req_ready_i;
            TGT_XIF: tgt_ready = xif_req_ready_i;
            default: tgt_ready = ram_req_ready_i;
        endcase
    end

    assign host_req_ready_o = !stall && tgt_ready;
    assign rd_accept = host_req_valid_i && host_req_ready_o && !host_we_i;

    // responses only come from the target of the outstanding reads
    always_comb
    begin
        case (rd_tgt)
            TGT_SFR:
            begin
                host_resp_valid_o = sfr_resp_valid_i;
                host_rdata_o      = sfr_rdata_i;
            end
            TGT_XIF:
            begin
                host_resp_valid_o = xif_resp_valid_i;
                host_rdata_o      = xif_rdata_i;
            end
            default:
            begin
                host_resp_valid_o = ram_resp_valid_i;
                host_rdata_o      = ram_rdata_i;
            end
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rd_cnt <= '0;
            rd_tgt <= TGT_RAM;
        end
        else
        begin
            rd_cnt <= rd_cnt + RD_CNT_W'(rd_accept) - RD_CNT_W'(host_resp_valid_o);
            if (rd_accept)
                rd_tgt <= req_tgt;
        end
    end

    a_one_target: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({ram_req_valid_o, sfr_req_valid_o, xif_req_valid_o}));

    a_no_stray_resp: assert property (@(posedge clk_i) disable iff (rst_i)
        (ram_resp_valid_i || sfr_resp_valid_i || xif_resp_valid_i) |-> (rd_cnt != '0));

endmodule

// ==== src/tile_ram.sv ====
module tile_ram
    import tile_pkg::*;
(
    input  logic              clk_i
    , input  logic              rst_i

    , input  logic              req_valid_i
    , input  logic              we_i
    , input  logic [ADDR_W-1:0] addr_i
    , input  logic [BE_W-1:0]   be_i
    , input  logic [DATA_W-1:0] wdata_i

    , output logic              resp_valid_o
    , output logic [DATA_W-1:0] rdata_o
);

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [RAM_AW-1:0] word_addr;

    // upper address bits alias
    assign word_addr = addr_i[RAM_AW+1:2];

    always_ff @(posedge clk_i)
    begin
        if (req_valid_i)
        begin
            if (we_i)
            begin
                for (int i = 0; i < BE_W; i++)
                begin
                    if (be_i[i])
                        mem[word_addr][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
            else
            begin
                rdata_o <= mem[word_addr];
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            resp_valid_o <= 1'b0;
        else
            resp_valid_o <= req_valid_i && !we_i;
    end

endmodule

// ==== src/tile_sfr.sv ====
module tile_sfr
    import tile_pkg::*;
#(
    parameter logic [DATA_W-1:0] CORE_ID = '0
)
(
    input  logic                   clk_i
    , input  logic                   rst_i

    , input  logic                   req_valid_i
    , input  logic                   we_i
    , input  logic [ADDR_W-1:0]      addr_i
    , input  logic [DATA_W-1:0]      wdata_i
    , output logic                   resp_valid_o
    , output logic [DATA_W-1:0]      rdata_o

    , output logic                   sw_reset_o
    , output logic [IRQ_NUM-1:0]     irq_en_o
    , output logic                   timer_irq_o
    , output logic                   sgi_req_o
    , output logic [IRQ_NUM_POW-1:0] sgi_code_o
);

    logic [SFR_OFS_W-3:0] reg_sel;
    logic                 wr;
    logic                 rd;
    logic [DATA_W-1:0]    timer_period;
    logic [DATA_W-1:0]    timer_value;
    logic [DATA_W-1:0]    rd_data;

    assign reg_sel = addr_i[SFR_OFS_W-1:2];
    assign wr = req_valid_i && we_i;
    assign rd = req_valid_i && !we_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            sw_reset_o <= SW_RESET_DEFAULT;
            irq_en_o   <= '0;
            sgi_req_o  <= 1'b0;
        end
        else
        begin
            sgi_req_o <= 1'b0;
            if (wr && (reg_sel == SFR_SW_RESET[SFR_OFS_W-1:2]))
                sw_reset_o <= wdata_i[0];
            if (wr && (reg_sel == SFR_IRQ_EN[SFR_OFS_W-1:2]))
                irq_en_o <= wdata_i[IRQ_NUM-1:0];
            if (wr && (reg_sel == SFR_SGI[SFR_OFS_W-1:2]))
                sgi_req_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wr && (reg_sel == SFR_SGI[SFR_OFS_W-1:2]))
            sgi_code_o <= wdata_i[IRQ_NUM_POW-1:0];
    end

    // interval timer, one pulse every period+1 cycles
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            timer_period <= '0;
            timer_value  <= '0;
            timer_irq_o  <= 1'b0;
        end
        else
        begin
            timer_irq_o <= 1'b0;
            if (wr && (reg_sel == SFR_TIMER_PERIOD[SFR_OFS_W-1:2]))
            begin
                timer_period <= wdata_i;
                timer_value  <= '0;
            end
            else if (timer_period == '0)
            begin
                timer_value <= '0;
            end
            else if (timer_value == timer_period)
            begin
                timer_value <= '0;
                timer_irq_o <= 1'b1;
            end
            else
            begin
                timer_value <= timer_value + 1'b1;
            end
        end
    end

    always_comb
    begin
        case (reg_sel)
            SFR_ID[SFR_OFS_W-1:2]:           rd_data = CORE_ID;
            SFR_SW_RESET[SFR_OFS_W-1:2]:     rd_data = DATA_W'(sw_reset_o);
            SFR_IRQ_EN[SFR_OFS_W-1:2]:       rd_data = DATA_W'(irq_en_o);
            SFR_TIMER_PERIOD[SFR_OFS_W-1:2]: rd_data = timer_period;
            SFR_TIMER_VALUE[SFR_OFS_W-1:2]:  rd_data = timer_value;
            // sgi trigger is write only
            default:                         rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rd)
            rdata_o <= rd_data;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            resp_valid_o <= 1'b0;
        else
            resp_valid_o <= rd;
    end

endmodule

// ==== src/irq_adapter.sv ====
module irq_adapter
    import tile_pkg::*;
(
    input  logic                   clk_i
    , input  logic                   rst_i

    , input  logic [IRQ_NUM-1:0]     irq_lines_i
    , input  logic                   timer_irq_i
    , input  logic [IRQ_NUM-1:0]     irq_en_i
    , input  logic                   sgi_req_i
    , input  logic [IRQ_NUM_POW-1:0] sgi_code_i

    , output logic                   irq_req_o
    , output logic [IRQ_NUM_POW-1:0] irq_code_o
    , input  logic                   irq_ack_i
);

    logic [IRQ_NUM-1:0]     masked;
    logic [IRQ_NUM-1:0]     pending;
    logic [IRQ_NUM-1:0]     clr_line;
    logic                   sgi_pend;
    logic [IRQ_NUM_POW-1:0] sgi_pend_code;
    logic                   req_is_sgi;
    logic                   line_found;
    logic [IRQ_NUM_POW-1:0] line_code;
    logic                   ack;

    assign masked = (irq_lines_i | (IRQ_NUM'(timer_irq_i) << TIMER_IRQ_LINE)) & irq_en_i;
    assign ack = irq_req_o && irq_ack_i;

    // lowest numbered pending line wins
    always_comb
    begin
        line_found = 1'b0;
        line_code  = '0;
        for (int i = IRQ_NUM - 1; i >= 0; i--)
        begin
            if (pending[i])
            begin
                line_found = 1'b1;
                line_code  = IRQ_NUM_POW'(i);
            end
        end
    end

    always_comb
    begin
        clr_line = '0;
        if (ack && !req_is_sgi)
            clr_line[irq_code_o] = 1'b1;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            pending    <= '0;
            sgi_pend   <= 1'b0;
            irq_req_o  <= 1'b0;
            req_is_sgi <= 1'b0;
        end
        else
        begin
            pending <= (pending & ~clr_line) | masked;

            // a fresh sgi overrides the ack of the one being served
            if (sgi_req_i)
                sgi_pend <= 1'b1;
            else if (ack && req_is_sgi)
                sgi_pend <= 1'b0;

            if (irq_req_o)
            begin
                if (irq_ack_i)
                    irq_req_o <= 1'b0;
            end
            else if (sgi_pend)
            begin
                irq_req_o  <= 1'b1;
                irq_code_o <= sgi_pend_code;
                req_is_sgi <= 1'b1;
            end
            else if (line_found)
            begin
                irq_req_o  <= 1'b1;
                irq_code_o <= line_code;
                req_is_sgi <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (sgi_req_i)
            sgi_pend_code <= sgi_code_i;
    end

    a_code_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (irq_req_o && !irq_ack_i) |=> (irq_req_o && $stable(irq_code_o)));

endmodule

// ==== src/sigma_tile.sv ====
module sigma_tile
    import tile_pkg::*;
#(
    parameter logic [DATA_W-1:0] CORE_ID = '0
)
(
    input  logic                   clk_i
    , input  logic                   rst_i

    , input  logic                   host_req_valid_i
    , output logic                   host_req_ready_o
    , input  logic                   host_we_i
    , input  logic [ADDR_W-1:0]      host_addr_i
    , input  logic [BE_W-1:0]        host_be_i
    , input  logic [DATA_W-1:0]      host_wdata_i
    , output logic                   host_resp_valid_o
    , output logic [DATA_W-1:0]      host_rdata_o

    , output logic                   xif_req_valid_o
    , input  logic                   xif_req_ready_i
    , output logic                   xif_we_o
    , output logic [ADDR_W-1:0]      xif_addr_o
    , output logic [BE_W-1:0]        xif_be_o
    , output logic [DATA_W-1:0]      xif_wdata_o
    , input  logic                   xif_resp_valid_i
    , input  logic [DATA_W-1:0]      xif_rdata_i

    , input  logic [IRQ_NUM-1:0]     irq_lines_i
    , output logic                   irq_req_o
    , output logic [IRQ_NUM_POW-1:0] irq_code_o
    , input  logic                   irq_ack_i

    , output logic                   sw_reset_o
);

    logic                   ram_req_valid;
    logic                   ram_we;
    logic [ADDR_W-1:0]      ram_addr;
    logic [BE_W-1:0]        ram_be;
    logic [DATA_W-1:0]      ram_wdata;
    logic                   ram_resp_valid;
    logic [DATA_W-1:0]      ram_rdata;

    logic                   sfr_req_valid;
    logic                   sfr_we;
    logic [ADDR_W-1:0]      sfr_addr;
    logic [DATA_W-1:0]      sfr_wdata;
    logic                   sfr_resp_valid;
    logic [DATA_W-1:0]      sfr_rdata;

    logic [IRQ_NUM-1:0]     irq_en;
    logic                   timer_irq;
    logic                   sgi_req;
    logic [IRQ_NUM_POW-1:0] sgi_code;

    // ram and sfr always accept
    tile_addr_decoder decoder (
        .clk_i               (clk_i)
        , .rst_i             (rst_i)
        , .host_req_valid_i  (host_req_valid_i)
        , .host_req_ready_o  (host_req_ready_o)
        , .host_we_i         (host_we_i)
        , .host_addr_i       (host_addr_i)
        , .host_be_i         (host_be_i)
        , .host_wdata_i      (host_wdata_i)
        , .host_resp_valid_o (host_resp_valid_o)
        , .host_rdata_o      (host_rdata_o)
        , .ram_req_valid_o   (ram_req_valid)
        , .ram_req_ready_i   (1'b1)
        , .ram_we_o          (ram_we)
        , .ram_addr_o        (ram_addr)
        , .ram_be_o          (ram_be)
        , .ram_wdata_o       (ram_wdata)
        , .ram_resp_valid_i  (ram_resp_valid)
        , .ram_rdata_i       (ram_rdata)
        , .sfr_req_valid_o   (sfr_req_valid)
        , .sfr_req_ready_i   (1'b1)
        , .sfr_we_o          (sfr_we)
        , .sfr_addr_o        (sfr_addr)
        , .sfr_be_o          ()
        , .sfr_wdata_o       (sfr_wdata)
        , .sfr_resp_valid_i  (sfr_resp_valid)
        , .sfr_rdata_i       (sfr_rdata)
        , .xif_req_valid_o   (xif_req_valid_o)
        , .xif_req_ready_i   (xif_req_ready_i)
        , .xif_we_o          (xif_we_o)
        , .xif_addr_o        (xif_addr_o)
        , .xif_be_o          (xif_be_o)
        , .xif_wdata_o       (xif_wdata_o)
        , .xif_resp_valid_i  (xif_resp_valid_i)
        , .xif_rdata_i       (xif_rdata_i)
    );

    tile_ram ram (
        .clk_i          (clk_i)
        , .rst_i        (rst_i)
        , .req_valid_i  (ram_req_valid)
        , .we_i         (ram_we)
        , .addr_i       (ram_addr)
        , .be_i         (ram_be)
        , .wdata_i      (ram_wdata)
        , .resp_valid_o (ram_resp_valid)
        , .rdata_o      (ram_rdata)
    );

    tile_sfr #(
        .CORE_ID(CORE_ID)
    ) sfr (
        .clk_i          (clk_i)
        , .rst_i        (rst_i)
        , .req_valid_i  (sfr_req_valid)
        , .we_i         (sfr_we)
        , .addr_i       (sfr_addr)
        , .wdata_i      (sfr_wdata)
        , .resp_valid_o (sfr_resp_valid)
        , .rdata_o      (sfr_rdata)
        , .sw_reset_o   (sw_reset_o)
        , .irq_en_o     (irq_en)
        , .timer_irq_o  (timer_irq)
        , .sgi_req_o    (sgi_req)
        , .sgi_code_o   (sgi_code)
    );

    // software reset also clears pending interrupts
    irq_adapter irq_adapter (
        .clk_i          (clk_i)
        , .rst_i        (rst_i || sw_reset_o)
        , .irq_lines_i  (irq_lines_i)
        , .timer_irq_i  (timer_irq)
        , .irq_en_i     (irq_en)
        , .sgi_req_i    (sgi_req)
        , .sgi_code_i   (sgi_code)
        , .irq_req_o    (irq_req_o)
        , .irq_code_o   (irq_code_o)
        , .irq_ack_i    (irq_ack_i)
    );

endmodule

// ==== sim/tb_sigma_tile.sv ====
module tb_sigma_tile
    import tile_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [DATA_W-1:0] CORE_ID  = 32'h0000_0007;
    localparam logic [ADDR_W-1:0] SFR_BASE = 32'h1 << SFR_BITSEL;
    localparam logic [ADDR_W-1:0] XIF_BASE = 32'h1 << XIF_BITSEL;
    localparam logic [DATA_W-1:0] XIF_KEY  = 32'ha5a5_a5a5;

    logic                   clk_i = 1'b0;
    logic                   rst_i;
    logic                   host_req_valid_i;
    logic                   host_req_ready_o;
    logic                   host_we_i;
    logic [ADDR_W-1:0]      host_addr_i;
    logic [BE_W-1:0]        host_be_i;
    logic [DATA_W-1:0]      host_wdata_i;
    logic                   host_resp_valid_o;
    logic [DATA_W-1:0]      host_rdata_o;
    logic                   xif_req_valid_o;
    logic                   xif_req_ready_i;
    logic                   xif_we_o;
    logic [ADDR_W-1:0]      xif_addr_o;
    logic [BE_W-1:0]        xif_be_o;
    logic [DATA_W-1:0]      xif_wdata_o;
    logic                   xif_resp_valid_i;
    logic [DATA_W-1:0]      xif_rdata_i;
    logic [IRQ_NUM-1:0]     irq_lines_i;
    logic                   irq_req_o;
    logic [IRQ_NUM_POW-1:0] irq_code_o;
    logic                   irq_ack_i;
    logic                   sw_reset_o;

    integer seed = 32'hc9f51159;
    int     cyc = 0;

    // reference model state
    logic [DATA_W-1:0]  ram_model [RAM_WORDS];
    logic [IRQ_NUM-1:0] m_irq_en;
    logic [DATA_W-1:0]  m_period;
    logic               m_swr;
    logic [IRQ_NUM-1:0] pend_model;
    logic [DATA_W-1:0]  exp_data [$];
    int                 exp_cyc [$];

    // expansion port bookkeeping
    logic [ADDR_W-1:0]  xif_exp_addr [$];
    logic [BE_W:0]      xif_exp_ctl [$];
    logic [DATA_W-1:0]  xif_exp_wdata [$];
    logic [DATA_W-1:0]  xif_rsp_data [$];
    int                 xif_rsp_due [$];
    int                 xif_last_due = 0;

    sigma_tile #(
        .CORE_ID(CORE_ID)
    ) dut (
        .clk_i               (clk_i)
        , .rst_i             (rst_i)
        , .host_req_valid_i  (host_req_valid_i)
        , .host_req_ready_o  (host_req_ready_o)
        , .host_we_i         (host_we_i)
        , .host_addr_i       (host_addr_i)
        , .host_be_i         (host_be_i)
        , .host_wdata_i      (host_wdata_i)
        , .host_resp_valid_o (host_resp_valid_o)
        , .host_rdata_o      (host_rdata_o)
        , .xif_req_valid_o   (xif_req_valid_o)
        , .xif_req_ready_i   (xif_req_ready_i)
        , .xif_we_o          (xif_we_o)
        , .xif_addr_o        (xif_addr_o)
        , .xif_be_o          (xif_be_o)
        , .xif_wdata_o       (xif_wdata_o)
        , .xif_resp_valid_i  (xif_resp_valid_i)
        , .xif_rdata_i       (xif_rdata_i)
        , .irq_lines_i       (irq_lines_i)
        , .irq_req_o         (irq_req_o)
        , .irq_code_o        (irq_code_o)
        , .irq_ack_i         (irq_ack_i)
        , .sw_reset_o        (sw_reset_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i)
        cyc <= cyc + 1;

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        stop_run();
    endtask

    function automatic int lowest_line(input logic [IRQ_NUM-1:0] p);
        int i;
        for (i = 0; i < IRQ_NUM; i++)
        begin
            if (p[i])
                return i;
        end
        return -1;
    endfunction

    // timer value is free running and never read back
    function automatic logic [DATA_W-1:0] sfr_read_model(input logic [ADDR_W-1:0] addr);
        case (addr[4:0])
            SFR_ID:           return CORE_ID;
            SFR_SW_RESET:     return DATA_W'(m_swr);
            SFR_IRQ_EN:       return DATA_W'(m_irq_en);
            SFR_TIMER_PERIOD: return m_period;
            default:          return '0;
        endcase
    endfunction

    // one host transfer, starts and ends 1 ns after a rising edge
    task automatic bus_access(input logic we, input logic [ADDR_W-1:0] addr,
                              input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] exp;
        int                n;
        int                i;
        exp = '0;
        if (addr[XIF_BITSEL])
        begin
            xif_exp_addr.push_back(addr);
            xif_exp_ctl.push_back({we, be});
            xif_exp_wdata.push_back(wdata);
            exp = addr ^ XIF_KEY;
        end
        else if (addr[SFR_BITSEL])
        begin
            if (we)
            begin
                case (addr[4:0])
                    SFR_SW_RESET:     m_swr = wdata[0];
                    SFR_IRQ_EN:       m_irq_en = wdata[IRQ_NUM-1:0];
                    SFR_TIMER_PERIOD: m_period = wdata;
                    default:          ;
                endcase
            end
            exp = sfr_read_model(addr);
        end
        else if (we)
        begin
            for (i = 0; i < BE_W; i++)
            begin
                if (be[i])
                    ram_model[addr[11:2]][8*i +: 8] = wdata[8*i +: 8];
            end
        end
        else
        begin
            exp = ram_model[addr[11:2]];
        end

        host_req_valid_i = 1'b1;
        host_we_i        = we;
        host_addr_i      = addr;
        host_be_i        = be;
        host_wdata_i     = wdata;
        n = 0;
        @(negedge clk_i);
        while (!host_req_ready_o)
        begin
            n++;
            if (n > 200)
                report_timeout("the host request to be accepted");
            @(negedge clk_i);
        end
        if (!we)
        begin
            exp_data.push_back(exp);
            exp_cyc.push_back(addr[XIF_BITSEL] ? -1 : cyc + 1);
        end
        @(posedge clk_i);
        #1;
        host_req_valid_i = 1'b0;
    endtask

    task automatic wait_reads_done();
        int n;
        n = 0;
        while (exp_data.size() != 0)
        begin
            n++;
            if (n > 300)
                report_timeout("outstanding read responses");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_irq_req(input int limit);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!irq_req_o)
        begin
            n++;
            if (n > limit)
                report_timeout("an interrupt request");
            @(negedge clk_i);
        end
    endtask

    task automatic ack_irq();
        @(posedge clk_i);
        #1;
        irq_ack_i = 1'b1;
        @(posedge clk_i);
        #1;
        irq_ack_i = 1'b0;
    endtask

    task automatic pulse_lines(input logic [IRQ_NUM-1:0] lines);
        irq_lines_i = lines;
        pend_model  = pend_model | (lines & m_irq_en);
        @(posedge clk_i);
        #1;
        irq_lines_i = '0;
    endtask

    task automatic serve_pending();
        int code;
        while (pend_model != '0)
        begin
            code = lowest_line(pend_model);
            wait_irq_req(20);
            check_value(irq_code_o, code, "served interrupt line");
            ack_irq();
            pend_model[code] = 1'b0;
        end
    endtask

    task automatic expect_irq_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk_i);
            check_value(irq_req_o, 1'b0, "irq_req_o with nothing pending");
        end
        @(posedge clk_i);
        #1;
    endtask

    // masks everything, stops the timer and flushes the adapter
    task automatic clear_irq();
        bus_access(1'b1, SFR_BASE | SFR_IRQ_EN, 4'hf, 32'h0);
        bus_access(1'b1, SFR_BASE | SFR_TIMER_PERIOD, 4'hf, 32'h0);
        bus_access(1'b1, SFR_BASE | SFR_SW_RESET, 4'hf, 32'h1);
        bus_access(1'b1, SFR_BASE | SFR_SW_RESET, 4'hf, 32'h0);
        pend_model = '0;
    endtask

    always @(negedge clk_i)
    begin : resp_monitor
        int due;
        if (!rst_i && host_resp_valid_o)
        begin
            if (exp_data.size() == 0)
            begin
                $display("a read response arrived with no read outstanding at %0t ns", $time);
                stop_run();
            end
            else
            begin
                check_value(host_rdata_o, exp_data.pop_front(), "host read data");
                due = exp_cyc.pop_front();
                if (due >= 0)
                    check_value(cyc, due, "read response cycle");
            end
        end
    end

    always @(negedge clk_i)
    begin : xif_accept
        int due;
        if (!rst_i && xif_req_valid_o && xif_req_ready_i)
        begin
            if (xif_exp_addr.size() == 0)
            begin
                $display("the expansion port took a request not meant for it at %0t ns", $time);
                stop_run();
            end
            else
            begin
                check_value(xif_addr_o, xif_exp_addr.pop_front(), "expansion address");
                check_value({xif_we_o, xif_be_o}, xif_exp_ctl.pop_front(), "expansion we and be");
                check_value(xif_wdata_o, xif_exp_wdata.pop_front(), "expansion write data");
                if (!xif_we_o)
                begin
                    // 1 to 6 cycles, answered in order
                    due = cyc + 1 + ($unsigned($random(seed)) % 6);
                    if (due <= xif_last_due)
                        due = xif_last_due + 1;
                    xif_last_due = due;
                    xif_rsp_data.push_back(xif_addr_o ^ XIF_KEY);
                    xif_rsp_due.push_back(due);
                end
            end
        end
    end

    always @(posedge clk_i)
    begin
        #1;
        xif_resp_valid_i = 1'b0;
        if (rst_i)
            xif_req_ready_i = 1'b0;
        else
        begin
            xif_req_ready_i = ($random(seed) & 3) != 0;
            if (xif_rsp_data.size() != 0 && cyc >= xif_rsp_due[0])
            begin
                void'(xif_rsp_due.pop_front());
                xif_rdata_i      = xif_rsp_data.pop_front();
                xif_resp_valid_i = 1'b1;
            end
        end
    end

    initial
    begin : main
        int                     i;
        int                     sel;
        int                     first;
        logic                   we;
        logic [ADDR_W-1:0]      addr;
        logic [IRQ_NUM-1:0]     lines;
        logic [IRQ_NUM_POW-1:0] sgi;

        rst_i            = 1'b1;
        host_req_valid_i = 1'b0;
        host_we_i        = 1'b0;
        host_addr_i      = '0;
        host_be_i        = '0;
        host_wdata_i     = '0;
        xif_req_ready_i  = 1'b0;
        xif_resp_valid_i = 1'b0;
        xif_rdata_i      = '0;
        irq_lines_i      = '0;
        irq_ack_i        = 1'b0;
        m_irq_en         = '0;
        m_period         = '0;
        m_swr            = SW_RESET_DEFAULT;
        pend_model       = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(negedge clk_i);
        check_value(host_resp_valid_o, 1'b0, "host_resp_valid_o after reset");
        check_value(xif_req_valid_o, 1'b0, "xif_req_valid_o after reset");
        check_value(irq_req_o, 1'b0, "irq_req_o after reset");
        check_value(sw_reset_o, SW_RESET_DEFAULT, "sw_reset_o after reset");
        @(posedge clk_i);
        #1;

        // ram with byte enables
        for (i = 0; i < 64; i++)
            bus_access(1'b1, ADDR_W'(i * 4), 4'hf, $random(seed));
        for (i = 0; i < 120; i++)
            bus_access(1'b1, ADDR_W'(($unsigned($random(seed)) % 64) * 4),
                       BE_W'($random(seed)), $random(seed));
        for (i = 0; i < 64; i++)
            bus_access(1'b0, ADDR_W'(i * 4), 4'hf, '0);
        wait_reads_done();

        // sfr readback
        bus_access(1'b0, SFR_BASE | SFR_ID, 4'hf, '0);
        for (i = 0; i < 8; i++)
        begin
            bus_access(1'b1, SFR_BASE | SFR_IRQ_EN, 4'hf, $random(seed));
            bus_access(1'b0, SFR_BASE | SFR_IRQ_EN, 4'hf, '0);
            bus_access(1'b1, SFR_BASE | SFR_TIMER_PERIOD, 4'hf, $random(seed));
            bus_access(1'b0, SFR_BASE | SFR_TIMER_PERIOD, 4'hf, '0);
            bus_access(1'b1, SFR_BASE | SFR_SW_RESET, 4'hf, $random(seed));
            check_value(sw_reset_o, m_swr, "sw_reset_o after write");
            bus_access(1'b0, SFR_BASE | SFR_SW_RESET, 4'hf, '0);
            bus_access(1'b0, SFR_BASE | SFR_SGI, 4'hf, '0);
        end
        wait_reads_done();

        // mixed traffic over all three targets
        for (i = 0; i < 300; i++)
        begin
            sel = $unsigned($random(seed)) % 3;
            we  = ($random(seed) & 1) != 0;
            if (sel == 0)
                addr = ADDR_W'(($unsigned($random(seed)) % 64) * 4);
            else if (sel == 1)
                addr = SFR_BASE | ADDR_W'(($unsigned($random(seed)) % 4) * 4);
            else
                addr = XIF_BASE | ($random(seed) & 32'h7fff_fffc);
            bus_access(we, addr, BE_W'($random(seed)), $random(seed));
        end
        wait_reads_done();
        check_value(xif_exp_addr.size(), 0, "expansion requests never seen");
        clear_irq();

        // line interrupts under a random mask
        bus_access(1'b1, SFR_BASE | SFR_IRQ_EN, 4'hf, $random(seed));
        for (i = 0; i < 16; i++)
        begin
            pulse_lines($random(seed));
            serve_pending();
            expect_irq_idle(3);
        end

        // sgi goes ahead of pending lines
        bus_access(1'b1, SFR_BASE | SFR_IRQ_EN, 4'hf, 32'hffff);
        lines = $random(seed);
        lines[IRQ_NUM-1] = 1'b1;
        pulse_lines(lines);
        first = lowest_line(pend_model);
        wait_irq_req(20);
        check_value(irq_code_o, first, "interrupt line before sgi");
        @(posedge clk_i);
        #1;
        sgi = $random(seed);
        bus_access(1'b1, SFR_BASE | SFR_SGI, 4'hf, DATA_W'(sgi));
        ack_irq();
        pend_model[first] = 1'b0;
        wait_irq_req(20);
        check_value(irq_code_o, sgi, "sgi code ahead of pending lines");
        ack_irq();
        serve_pending();
        expect_irq_idle(3);

        // software reset flushes the adapter
        pulse_lines($random(seed) | 32'h1);
        wait_irq_req(20);
        @(posedge clk_i);
        #1;
        bus_access(1'b1, SFR_BASE | SFR_SW_RESET, 4'hf, 32'h1);
        check_value(sw_reset_o, 1'b1, "sw_reset_o set");
        bus_access(1'b1, SFR_BASE | SFR_SW_RESET, 4'hf, 32'h0);
        check_value(sw_reset_o, 1'b0, "sw_reset_o cleared");
        pend_model = '0;
        expect_irq_idle(8);
        lines = '0;
        lines[$unsigned($random(seed)) % IRQ_NUM] = 1'b1;
        pulse_lines(lines);
        serve_pending();
        expect_irq_idle(3);

        // periodic timer on its own line
        bus_access(1'b1, SFR_BASE | SFR_IRQ_EN, 4'hf, 32'h1 << TIMER_IRQ_LINE);
        bus_access(1'b1, SFR_BASE | SFR_TIMER_PERIOD, 4'hf, 32'd20);
        for (i = 0; i < 2; i++)
        begin
            wait_irq_req(40);
            check_value(irq_code_o, TIMER_IRQ_LINE, "timer interrupt line");
            ack_irq();
        end
        clear_irq();
        wait_reads_done();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
src/tile_pkg.sv
src/tile_addr_decoder.sv
src/tile_ram.sv
src/tile_sfr.sv
src/irq_adapter.sv
src/sigma_tile.sv
sim/tb_sigma_tile.sv
